/* build.f */
rtl/elinkPkg.sv
rtl/elinkFrameGen.sv
rtl/enc8b10b.sv
rtl/elinkSerializer.sv
rtl/elinkDeserializer.sv
rtl/dec8b10b.sv
rtl/elinkLoopback.sv
verif/elinkLoopbackTb.sv

/* Makefile */
# Verilator flow for the e-link loopback

VERILATOR ?= verilator
TOP       ?= elinkLoopbackTb
RTL_TOP   ?= elinkLoopback
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/elinkLoopbackTb.sv */
`timescale 1ns/1ps
module elinkLoopbackTb;
  import elinkPkg::*;

  localparam int clkPeriod = 40;
  localparam int drvDly = 4;      // inputs change this long after the rising edge
  localparam int rstCycles = 5;
  localparam int numRows = 8;
  localparam int numFixed = 5;    // rows past this come from $random
  localparam int idleLead = 4;    // idle words seen before the first frame
  localparam int idleTail = 4;    // idle words seen after the last frame
  localparam int lockMargin = 200;
  localparam logic [0:9] idleNegCode = 10'b0011111010;  // K28.5 RD- as abcdei fghj

  logic getDataTrig;
  logic rstN;
  logic enable;
  logic [7:0] frameLen;
  logic [7:0] startByte;
  logic frameDone;
  logic [symW-1:0] serOut;
  logic [7:0] rxData;
  logic rxIsK;
  logic rxValid;
  logic codeErr;
  logic dispErr;
  logic aligned;

  // stimulus table with one frame per row
  logic [7:0] lenTab [numRows];
  logic [7:0] startTab [numRows];

  logic [8:0] expQ [$];  // {isK, byte} still owed by the link
  logic [8:0] expWord;
  integer seed;
  int budget;
  int doneCount;
  int idleWords;
  int tailStart;
  logic tableReady;

  elinkLoopback dut_i (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .enable      (enable),
    .frameLen    (frameLen),
    .startByte   (startByte),
    .frameDone   (frameDone),
    .serOut      (serOut),
    .rxData      (rxData),
    .rxIsK       (rxIsK),
    .rxValid     (rxValid),
    .codeErr     (codeErr),
    .dispErr     (dispErr),
    .aligned     (aligned)
  );

  initial
  begin
    getDataTrig = 1'b0;
    forever #(clkPeriod / 2) getDataTrig = ~getDataTrig;
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic checkEq(input string sigName, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abortRun($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", sigName, got, exp));
  endtask

  // hand-picked rows first and a few random ones after
  task automatic fillTable();
    logic [31:0] rnd;
    lenTab[0] = 8'd4;
    startTab[0] = 8'h10;
    lenTab[1] = 8'd0;
    startTab[1] = 8'h55;  // empty frame
    lenTab[2] = 8'd6;
    startTab[2] = 8'hFC;  // wraps past 0xFF
    lenTab[3] = 8'd1;
    startTab[3] = 8'hFF;
    lenTab[4] = 8'd12;
    startTab[4] = 8'hF8;
    for (int r = numFixed; r < numRows; r++)
    begin
      rnd = $random(seed);
      lenTab[r] = {3'b000, rnd[4:0]};  // keep frames short
      startTab[r] = rnd[15:8];
    end
  endtask

  // model queues SOP then counting bytes then EOP
  task automatic queueFrame(input logic [7:0] len, input logic [7:0] first);
    expQ.push_back({1'b1, kSop});
    for (int i = 0; i < int'(len); i++)
      expQ.push_back({1'b0, 8'(int'(first) + i)});  // mod 256
    expQ.push_back({1'b1, kEop});
  endtask

  // receive monitor samples on the falling edge where registered outputs are quiet
  initial
  begin
    idleWords = 0;
    doneCount = 0;
    forever
    begin
      @(negedge getDataTrig);
      if (rstN && frameDone)
        doneCount++;  // one pulse per frame
      if (rstN && rxValid)
      begin
        checkEq("aligned", 32'(aligned), 32'd1);  // no word before lock
        checkEq("codeErr", 32'(codeErr), 32'd0);
        checkEq("dispErr", 32'(dispErr), 32'd0);
        if (rxIsK && rxData == kIdle)
          idleWords++;  // filler is never queued
        else if (expQ.size() == 0)
          abortRun($sformatf("unexpected word 0x%0h with K flag %0b on an idle link",
                             rxData, rxIsK));
        else
        begin
          expWord = expQ.pop_front();
          checkEq("rxIsK", 32'(rxIsK), 32'(expWord[8]));
          checkEq("rxData", 32'(rxData), 32'(expWord[7:0]));
        end
      end
    end
  end

  // watchdog sized from the table
  initial
  begin
    wait (tableReady === 1'b1);
    repeat (budget) @(posedge getDataTrig);
    abortRun($sformatf("timeout after %0d clock cycles, link never finished", budget));
  end

  initial
  begin
    tableReady = 1'b0;
    seed = 14;
    rstN = 1'b0;
    enable = 1'b0;
    frameLen = 8'd0;
    startByte = 8'd0;
    fillTable();
    budget = lockMargin + (idleLead + idleTail) * wordSyms;
    for (int r = 0; r < numRows; r++)
      budget += (int'(lenTab[r]) + 10) * wordSyms;
    tableReady = 1'b1;

    repeat (rstCycles) @(posedge getDataTrig);
    checkEq("aligned", 32'(aligned), 32'd0);
    checkEq("rxValid", 32'(rxValid), 32'd0);
    #drvDly rstN = 1'b1;

    // first word on the line is the reset preload, bit pair a b leads
    for (int s = 0; s < wordSyms; s++)
    begin
      @(negedge getDataTrig);
      checkEq("serOut", 32'(serOut), 32'({idleNegCode[2*s+1], idleNegCode[2*s]}));
    end

    // lock on the reset preload and see a few idles with enable low
    while (aligned !== 1'b1)
    begin
      @(posedge getDataTrig);
      #drvDly;
    end
    while (idleWords < idleLead)
      @(posedge getDataTrig);

    @(posedge getDataTrig);
    #drvDly;
    for (int r = 0; r < numRows; r++)
    begin
      frameLen = lenTab[r];    // latched at the next SOP
      startByte = startTab[r];
      enable = 1'b1;
      queueFrame(lenTab[r], startTab[r]);
      do
      begin
        @(posedge getDataTrig);
        #drvDly;
      end
      while (frameDone !== 1'b1);
    end
    enable = 1'b0;  // drops before the next request so no extra frame starts

    // drain the queue and let only idles follow
    while (expQ.size() != 0)
      @(posedge getDataTrig);
    tailStart = idleWords;
    while (idleWords < tailStart + idleTail)
      @(posedge getDataTrig);

    if (doneCount == numRows)
    begin
      $display("Test passed");
      $finish;
    end
    else
      abortRun($sformatf("ERROR frameDone pulses: got 0x%0h, expected 0x%0h",
                         doneCount, numRows));
  end

endmodule

/* rtl/elinkLoopback.sv */
`timescale 1ns/1ps
module elinkLoopback (
  input  logic                      getDataTrig,
  input  logic                      rstN,
  input  logic                      enable,
  input  logic [7:0]                frameLen,
  input  logic [7:0]                startByte,
  output logic                      frameDone,
  output logic [elinkPkg::symW-1:0] serOut,
  output logic [7:0]                rxData,
  output logic                      rxIsK,
  output logic                      rxValid,
  output logic                      codeErr,
  output logic                      dispErr,
  output logic                      aligned
);
  import elinkPkg::*;

  logic wordReq;
  logic [7:0] genByte;
  logic genIsK;
  logic genRdy;
  logic [wordW-1:0] encWord;
  logic [wordW-1:0] alignWord;
  logic wordValid;

  // transmit side
  elinkFrameGen genI (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .enable      (enable),
    .frameLen    (frameLen),
    .startByte   (startByte),
    .wordReq     (wordReq),
    .byteOut     (genByte),
    .isKOut      (genIsK),
    .dataRdy     (genRdy),
    .frameDone   (frameDone)
  );

  enc8b10b encI (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .byteIn      (genByte),
    .isKIn       (genIsK),
    .dataRdy     (genRdy),
    .encWord     (encWord),
    .encRdy      ()  // serializer runs on its own slot count
  );

  elinkSerializer serI (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .encWord     (encWord),
    .serOut      (serOut),
    .wordReq     (wordReq)
  );

  // receive side, fed straight from the line
  elinkDeserializer desI (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .serIn       (serOut),
    .alignWord   (alignWord),
    .wordValid   (wordValid),
    .aligned     (aligned)
  );

  dec8b10b decI (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .wordIn      (alignWord),
    .wordValid   (wordValid),
    .rxData      (rxData),
    .rxIsK       (rxIsK),
    .codeErr     (codeErr),
    .dispErr     (dispErr),
    .rxValid     (rxValid)
  );

endmodule

/* rtl/dec8b10b.sv */
`timescale 1ns/1ps
module dec8b10b (
  input  logic                       getDataTrig,
  input  logic                       rstN,
  input  logic [elinkPkg::wordW-1:0] wordIn,
  input  logic                       wordValid,
  output logic [7:0]                 rxData,
  output logic                       rxIsK,
  output logic                       codeErr,
  output logic                       dispErr,
  output logic                       rxValid
);
  import elinkPkg::*;

  logic rd;  // own running disparity, high = positive
  logic [wordW-1:0] lineCode;
  logic [5:0] c6;
  logic [3:0] c4;
  logic [3:0] c4Look;
  logic [2:0] ones6;
  logic [2:0] ones4;
  logic [4:0] xDec;
  logic [2:0] yDec;
  logic isK28;
  logic hit6;
  logic hit4;
  logic rd6;
  logic rdNext;
  logic dErr;

  always_comb
  begin
    lineCode = {<<{wordIn}};  // back to abcdei fghj order
    c6 = lineCode[9:4];
    c4 = lineCode[3:0];
    ones6 = 3'($countones(c6));
    ones4 = 3'($countones(c4));
    // 6b inverse, complement only where the encoder alternates
    isK28 = (c6 == codeK28) || (c6 == ~codeK28);
    hit6 = isK28;
    xDec = isK28 ? 5'd28 : 5'd0;
    for (int i = 0; i < 32; i++)
    begin
      if (c6 == code5b6b[i] ||
          (c6 == ~code5b6b[i] && ($countones(code5b6b[i]) != 3 || i == 7)))
      begin
        hit6 = 1'b1;
        xDec = 5'(i);
      end
    end
    // 4b inverse, K28 after a negative 6b part is stored flipped
    c4Look = (isK28 && c6 == ~codeK28) ? ~c4 : c4;
    hit4 = (c4Look == codeA7) || (c4Look == ~codeA7);
    yDec = hit4 ? 3'd7 : 3'd0;
    for (int i = 0; i < 8; i++)
    begin
      if (c4Look == code3b4b[i] ||
          (c4Look == ~code3b4b[i] && ($countones(code3b4b[i]) != 2 || i == 3)))
      begin
        hit4 = 1'b1;
        yDec = 3'(i);
      end
    end
    // disparity per sub-block
    dErr = 1'b0;
    rd6 = rd;
    if (ones6 == 3'd4)
    begin
      dErr = rd;      // +2 needs negative before it
      rd6 = 1'b1;
    end
    else if (ones6 == 3'd2)
    begin
      dErr = !rd;
      rd6 = 1'b0;
    end
    rdNext = rd6;
    if (ones4 == 3'd3)
    begin
      dErr = dErr | rd6;
      rdNext = 1'b1;
    end
    else if (ones4 == 3'd1)
    begin
      dErr = dErr | !rd6;
      rdNext = 1'b0;
    end
  end

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      rd <= rstDisp;
      rxValid <= 1'b0;
      codeErr <= 1'b0;
      dispErr <= 1'b0;
    end
    else
    begin
      rxValid <= wordValid;
      if (wordValid)
      begin
        rd <= rdNext;
        codeErr <= !(hit6 && hit4);
        dispErr <= dErr;
      end
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (wordValid)
    begin
      rxData <= {yDec, xDec};  // HGF EDCBA
      rxIsK <= isK28;
    end
  end

endmodule

/* rtl/elinkDeserializer.sv */
`timescale 1ns/1ps
module elinkDeserializer (
  input  logic                       getDataTrig,
  input  logic                       rstN,
  input  logic [elinkPkg::symW-1:0]  serIn,
  output logic [elinkPkg::wordW-1:0] alignWord,
  output logic                       wordValid,
  output logic                       aligned
);
  import elinkPkg::*;

  logic [2*wordW-1:0] hist;  // newest symbol on top
  logic [2:0] lockOff;       // symbol offset of word bit a
  logic [2:0] phCnt;         // clocks since last word out
  logic [2:0] hitOff;
  logic hitFound;
  logic [2:0] selOff;
  logic emit;

  // comma search over the five symbol offsets, lowest hit wins
  always_comb
  begin
    hitFound = 1'b0;
    hitOff = '0;
    for (int off = wordSyms - 1; off >= 0; off--)
    begin
      if (hist[2*off +: 7] == commaNeg || hist[2*off +: 7] == commaPos)
      begin
        hitFound = 1'b1;
        hitOff = 3'(off);
      end
    end
    selOff = aligned ? lockOff : hitOff;
    emit = aligned ? (phCnt == 3'd0) : hitFound;  // first comma goes out too
  end

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      hist <= '0;  // zeros never look like a comma
      aligned <= 1'b0;
      lockOff <= '0;
      phCnt <= '0;
      wordValid <= 1'b0;
    end
    else
    begin
      hist <= {serIn, hist[2*wordW-1:symW]};
      wordValid <= emit;
      if (!aligned && hitFound)
      begin
        aligned <= 1'b1;  // locks for good
        lockOff <= hitOff;
        phCnt <= 3'd1;
      end
      else if (aligned)
        phCnt <= (phCnt == 3'(wordSyms - 1)) ? 3'd0 : phCnt + 3'd1;
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (emit)
      alignWord <= hist[{selOff, 1'b0} +: wordW];
  end

  // words only after lock, then strictly every five clocks
  wordPaceA: assert property (@(posedge getDataTrig) disable iff (!rstN)
    wordValid |-> aligned ##1 (!wordValid) [*4] ##1 wordValid);

endmodule

/* rtl/elinkSerializer.sv */
`timescale 1ns/1ps
module elinkSerializer (
  input  logic                       getDataTrig,
  input  logic                       rstN,
  input  logic [elinkPkg::wordW-1:0] encWord,
  output logic [elinkPkg::symW-1:0]  serOut,
  output logic                       wordReq
);
  import elinkPkg::*;

  logic [2:0] symCnt;           // symbol slot of the word on the wire
  logic [wordW-1:0] shiftReg;

  assign serOut = shiftReg[symW-1:0];  // low pair leaves first
  assign wordReq = (symCnt == 3'd2);   // three clocks ahead of the next load

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      symCnt <= '0;
      shiftReg <= {3'b010, commaNeg};  // K28.5 at negative disparity
    end
    else if (symCnt == 3'(wordSyms - 1))
    begin
      symCnt <= '0;
      shiftReg <= encWord;  // new word enters as the count wraps to 0
    end
    else
    begin
      symCnt <= symCnt + 3'd1;
      shiftReg <= shiftReg >> symW;
    end
  end

endmodule

/* rtl/enc8b10b.sv */
`timescale 1ns/1ps
module enc8b10b (
  input  logic                       getDataTrig,
  input  logic                       rstN,
  input  logic [7:0]                 byteIn,
  input  logic                       isKIn,
  input  logic                       dataRdy,
  output logic [elinkPkg::wordW-1:0] encWord,
  output logic                       encRdy
);
  import elinkPkg::*;

  logic rd;          // running disparity, high = positive
  logic [4:0] x;     // EDCBA
  logic [2:0] y;     // HGF
  logic [5:0] base6;
  logic [5:0] code6;
  logic [3:0] base4;
  logic [3:0] code4;
  logic unbal6;
  logic unbal4;
  logic rd6;         // disparity between the sub-blocks
  logic useA7;
  logic rdNext;
  logic [wordW-1:0] lineCode;  // a at the top

  always_comb
  begin
    x = byteIn[4:0];
    y = byteIn[7:5];
    // 5b6b part
    base6 = isKIn ? codeK28 : code5b6b[x];  // only K28.y control codes exist here
    unbal6 = ($countones(base6) != 3);
    code6 = (rd && (unbal6 || (!isKIn && x == 5'd7))) ? ~base6 : base6;  // D.07 alternates too
    rd6 = rd ^ unbal6;
    // 3b4b part
    useA7 = (y == 3'd7) && (isKIn || (rd6 ? (x == 5'd11 || x == 5'd13 || x == 5'd14)
                                          : (x == 5'd17 || x == 5'd18 || x == 5'd20)));
    base4 = useA7 ? codeA7 : code3b4b[y];  // A7 avoids a run of five
    unbal4 = ($countones(base4) != 2);
    code4 = (rd6 && (unbal4 || y == 3'd3)) ? ~base4 : base4;
    // K28 flips its balanced 4b codes once the 6b part went negative
    if (isKIn && !rd6 && !unbal4 && y != 3'd3)
      code4 = ~code4;
    rdNext = rd6 ^ unbal4;
    lineCode = {code6, code4};
  end

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      rd <= ~rstDisp;  // serializer preload already sent K28.5 at rstDisp
      encRdy <= 1'b0;
    end
    else
    begin
      encRdy <= dataRdy;
      if (dataRdy)
        rd <= rdNext;
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (dataRdy)
      encWord <= {<<{lineCode}};  // a goes to bit 0, first on the wire
  end

  // every word balanced or off by two
  wordDispA: assert property (@(posedge getDataTrig) disable iff (!rstN)
    encRdy |-> ($countones(encWord) inside {4, 5, 6}));

endmodule

/* rtl/elinkFrameGen.sv */
`timescale 1ns/1ps
module elinkFrameGen (
  input  logic       getDataTrig,
  input  logic       rstN,
  input  logic       enable,
  input  logic [7:0] frameLen,
  input  logic [7:0] startByte,
  input  logic       wordReq,
  output logic [7:0] byteOut,
  output logic       isKOut,
  output logic       dataRdy,
  output logic       frameDone
);
  import elinkPkg::*;

  typedef enum logic [1:0] {sIdle, sPay, sEop} stateT;

  stateT state;       // word to send on the next request
  logic [7:0] remain; // payload bytes still owed
  logic [7:0] payByte;

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= sIdle;
      dataRdy <= 1'b0;
      frameDone <= 1'b0;
    end
    else
    begin
      dataRdy <= wordReq;                          // answer one clock later
      frameDone <= wordReq && (state == sEop);     // goes out with EOP
      if (wordReq)
      begin
        case (state)
          sIdle:
            if (enable)
              state <= (frameLen == 8'd0) ? sEop : sPay;  // empty frame skips payload
          sPay:
            if (remain == 8'd1)
              state <= sEop;
          default:
            state <= sIdle;
        endcase
      end
    end
  end

  // byte and frame counters
  always_ff @(posedge getDataTrig)
  begin
    if (wordReq)
    begin
      case (state)
        sIdle:
        begin
          byteOut <= enable ? kSop : kIdle;
          isKOut <= 1'b1;
          if (enable)
          begin
            payByte <= startByte;  // frame settings frozen here
            remain <= frameLen;
          end
        end
        sPay:
        begin
          byteOut <= payByte;
          isKOut <= 1'b0;
          payByte <= payByte + 8'd1;  // wraps past 0xFF
          remain <= remain - 8'd1;
        end
        default:
        begin
          byteOut <= kEop;
          isKOut <= 1'b1;
        end
      endcase
    end
  end

  // one answer per request, requests come five clocks apart
  reqRdyA: assert property (@(posedge getDataTrig) disable iff (!rstN)
    wordReq |=> dataRdy ##1 (!dataRdy) [*4]);

endmodule

/* rtl/elinkPkg.sv */
package elinkPkg;

  // serial link geometry
  localparam int symW = 2;       // bits per clock on the e-link
  localparam int wordW = 10;     // one 8b10b word
  localparam int wordSyms = 5;   // symbols per word

  // control bytes, all K28.y
  localparam logic [7:0] kSop = 8'h3C;   // K28.1 start of packet
  localparam logic [7:0] kEop = 8'hDC;   // K28.6 end of packet
  localparam logic [7:0] kIdle = 8'hBC;  // K28.5 idle comma

  // comma prefix abcdeif, bit a sits at bit 0 like on the wire
  localparam logic [6:0] commaNeg = 7'b1111100;  // sent at negative disparity
  localparam logic [6:0] commaPos = 7'b0000011;  // sent at positive disparity

  localparam logic rstDisp = 1'b0;  // negative, 1 would mean positive

  // code tables below read abcdei / fghj left to right, RD- column only
  localparam logic [5:0] codeK28 = 6'b001111;
  localparam logic [3:0] codeA7 = 4'b0111;  // alternate x.7

  localparam logic [5:0] code5b6b [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001,  // D.00 .. D.03
    6'b110101, 6'b101001, 6'b011001, 6'b111000,  // D.04 .. D.07
    6'b111001, 6'b100101, 6'b010101, 6'b110100,  // D.08 .. D.11
    6'b001101, 6'b101100, 6'b011100, 6'b010111,  // D.12 .. D.15
    6'b011011, 6'b100011, 6'b010011, 6'b110010,  // D.16 .. D.19
    6'b001011, 6'b101010, 6'b011010, 6'b111010,  // D.20 .. D.23
    6'b110011, 6'b100110, 6'b010110, 6'b110110,  // D.24 .. D.27
    6'b001110, 6'b101110, 6'b011110, 6'b101011   // D.28 .. D.31
  };

  localparam logic [3:0] code3b4b [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100,  // x.0 .. x.3
    4'b1101, 4'b1010, 4'b0110, 4'b1110   // x.4 .. x.P7
  };

endpackage
